// ==== tb.f ====
verilog/occ_stats_pkg.sv
verilog/cs_gen.sv
verilog/min_select.sv
verilog/pop_counter.sv
verilog/sat_accumulator.sv
verilog/stats_ctrl.sv
verilog/occ_stats_top.sv
tests/tb_clock.sv
tests/tb_occ_stats.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the occupancy statistics testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f tb.f --top-module tb_occ_stats -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_occ_stats > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$SIM_LOG"; then
    exit 0
fi
exit 1

// ==== tests/tb_occ_stats.sv ====
module tb_occ_stats;
    timeunit 1ns;
    timeprecision 1ps;
    import occ_stats_pkg::*;

    // one table row
    // expected value ignored when vld is low
    typedef struct packed {
        logic    vld;
        sample_t smp;
        stats_t  exp;
    } entry_t;

    logic    clk;
    logic    rst;
    logic    in_valid;
    sample_t in_sample;
    logic    out_valid;
    stats_t  out_stats;

    entry_t  tbl [$];
    stats_t  exp_q [$];
    int      cyc_q [$];
    int      cyc;
    int      err_valid;
    int      err_stats;
    int      err_timeout;
    integer  seed;
    logic    exp_v;
    stats_t  exp_s;

    tb_clock clk_gen0 (
        .clk (clk),
        .rst (rst)
    );

    occ_stats_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .out_valid (out_valid),
        .out_stats (out_stats)
    );

    function automatic stats_t mk_stats(input int port, input int occ, input int cnt,
                                        input logic single, input int sum);
        stats_t r;
        r.min_port = PORT_W'(port);
        r.min_occ = OCC_W'(occ);
        r.req_count = CNT_W'(cnt);
        r.req_single = single;
        r.occ_sum = SUM_W'(sum);
        return r;
    endfunction

    // reference model of the unit
    // lowest value wins and the earliest port takes a tie
    // sum clipped at 127
    function automatic stats_t ref_stats(input sample_t smp);
        int best;
        int total;
        int ones;
        int p;
        int v;
        best = 0;
        total = 0;
        ones = 0;
        for (p = 0; p < NUM_PORTS; p++) begin
            v = int'(smp.occ[p*OCC_W +: OCC_W]);
            total = total + v;
            if (v < int'(smp.occ[best*OCC_W +: OCC_W])) begin
                best = p;
            end
            if (smp.req[p]) begin
                ones = ones + 1;
            end
        end
        if (total > 127) begin
            total = 127;
        end
        return mk_stats(best, int'(smp.occ[best*OCC_W +: OCC_W]), ones, ones <= 1, total);
    endfunction

    task automatic add_entry(input logic vld, input occ_vec_t occ, input port_mask_t req,
                             input stats_t exp);
        entry_t e;
        e.vld = vld;
        e.smp.occ = occ;
        e.smp.req = req;
        e.exp = exp;
        tbl.push_back(e);
    endtask

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR out_valid expected %h got %h at cycle %0d", exp, act, cyc);
            err_valid++;
        end
    endtask

    task automatic check_stats(input stats_t exp, input stats_t act);
        if (act.min_port !== exp.min_port) begin
            $display("ERROR out_stats.min_port expected %h got %h", exp.min_port, act.min_port);
            err_stats++;
        end
        if (act.min_occ !== exp.min_occ) begin
            $display("ERROR out_stats.min_occ expected %h got %h", exp.min_occ, act.min_occ);
            err_stats++;
        end
        if (act.req_count !== exp.req_count) begin
            $display("ERROR out_stats.req_count expected %h got %h",
                     exp.req_count, act.req_count);
            err_stats++;
        end
        if (act.req_single !== exp.req_single) begin
            $display("ERROR out_stats.req_single expected %h got %h",
                     exp.req_single, act.req_single);
            err_stats++;
        end
        if (act.occ_sum !== exp.occ_sum) begin
            $display("ERROR out_stats.occ_sum expected %h got %h", exp.occ_sum, act.occ_sum);
            err_stats++;
        end
    endtask

    task automatic build_table();
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        sample_t     smp;
        int          n;
        // occupancy words list port 7 first
        add_entry(1'b1, {5'd25, 5'd9, 5'd4, 5'd12, 5'd2, 5'd20, 5'd8, 5'd15}, 8'h00,
                  mk_stats(3, 2, 0, 1'b1, 95));
        // tie on 3 where port 2 is the earliest
        add_entry(1'b1, {5'd6, 5'd3, 5'd14, 5'd3, 5'd9, 5'd3, 5'd7, 5'd10}, 8'h10,
                  mk_stats(2, 3, 1, 1'b1, 55));
        add_entry(1'b1, {8{5'd17}}, 8'hff, mk_stats(0, 17, 8, 1'b0, 127));
        add_entry(1'b0, {8{5'd1}}, 8'h01, '0);
        add_entry(1'b1, {8{5'd31}}, 8'ha6, mk_stats(0, 31, 4, 1'b0, 127));
        // two idle cycles in a row
        add_entry(1'b0, '0, '0, '0);
        add_entry(1'b0, {8{5'd30}}, 8'h3c, '0);
        // sum right at the clip point and then one past it
        add_entry(1'b1, {5'd0, 5'd0, 5'd0, 5'd3, 5'd31, 5'd31, 5'd31, 5'd31}, 8'h03,
                  mk_stats(5, 0, 2, 1'b0, 127));
        add_entry(1'b1, {5'd0, 5'd0, 5'd0, 5'd4, 5'd31, 5'd31, 5'd31, 5'd31}, 8'h80,
                  mk_stats(5, 0, 1, 1'b1, 127));
        add_entry(1'b1, {5'd1, {7{5'd20}}}, 8'h7f, mk_stats(7, 1, 7, 1'b0, 127));
        // random rows with about three in four valid
        for (n = 0; n < 24; n++) begin
            r_hi = $random(seed);
            r_lo = $random(seed);
            smp.occ = {r_hi[7:0], r_lo};
            smp.req = r_hi[15:8];
            add_entry(r_hi[31:30] != 2'b00, smp.occ, smp.req, ref_stats(smp));
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // result due when the head of the queue names this cycle
    always @(negedge clk) begin
        if (!rst) begin
            exp_v = (cyc_q.size() != 0) && (cyc_q[0] == cyc);
            check_valid(exp_v, out_valid);
            if (exp_v) begin
                exp_s = exp_q.pop_front();
                void'(cyc_q.pop_front());
                if (out_valid) begin
                    check_stats(exp_s, out_stats);
                end
            end
        end
    end

    initial begin
        int idx;
        int waited;
        err_valid = 0;
        err_stats = 0;
        err_timeout = 0;
        seed = 32'h14fb_9101;
        in_valid = 1'b0;
        in_sample = '0;
        build_table();
        waited = 0;
        // reset is known high from the first edge on
        @(posedge clk);
        while (rst && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (rst) begin
            $display("reset never released");
            err_timeout++;
        end else begin
            // idle outputs after reset
            @(negedge clk);
            check_valid(1'b0, out_valid);
            check_stats('0, out_stats);
            for (idx = 0; idx < tbl.size(); idx++) begin
                @(posedge clk);
                #1;
                in_valid = tbl[idx].vld;
                in_sample = tbl[idx].smp;
                if (tbl[idx].vld) begin
                    exp_q.push_back(tbl[idx].exp);
                    cyc_q.push_back(cyc + 2);
                end
            end
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            waited = 0;
            while (exp_q.size() != 0 && waited < 10) begin
                @(posedge clk);
                waited++;
            end
            if (exp_q.size() != 0) begin
                $display("out_valid never rose for %0d pending results", exp_q.size());
                err_timeout++;
            end
        end
        $display("errors: valid %0d, stats %0d, timeout %0d",
                 err_valid, err_stats, err_timeout);
        if (err_valid + err_stats + err_timeout == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held over three rising edges, released just after the third
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== verilog/occ_stats_top.sv ====
module occ_stats_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  occ_stats_pkg::sample_t in_sample,
    output logic                   out_valid,
    output occ_stats_pkg::stats_t  out_stats
);
    import occ_stats_pkg::*;

    // staged sample fanned out to the datapath
    sample_t           s1_sample;

    // combinational results back to the control
    logic [PORT_W-1:0] min_port;
    occ_t              min_occ;
    logic [CNT_W-1:0]  req_count;
    logic [SUM_W-1:0]  occ_sum;

    stats_ctrl ctrl0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .s1_sample (s1_sample),
        .min_port  (min_port),
        .min_occ   (min_occ),
        .req_count (req_count),
        .occ_sum   (occ_sum),
        .out_valid (out_valid),
        .out_stats (out_stats)
    );

    min_select min0 (
        .occ      (s1_sample.occ),
        .min_port (min_port),
        .min_occ  (min_occ)
    );

    // request mask counter
    pop_counter #(
        .IN_WIDTH (NUM_PORTS)
    ) cnt0 (
        .in    (s1_sample.req),
        .count (req_count)
    );

    sat_accumulator acc0 (
        .occ (s1_sample.occ),
        .sum (occ_sum)
    );

endmodule

// ==== verilog/stats_ctrl.sv ====
module stats_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             in_valid,
    input  occ_stats_pkg::sample_t           in_sample,
    output occ_stats_pkg::sample_t           s1_sample,
    input  logic [occ_stats_pkg::PORT_W-1:0] min_port,
    input  occ_stats_pkg::occ_t              min_occ,
    input  logic [occ_stats_pkg::CNT_W-1:0]  req_count,
    input  logic [occ_stats_pkg::SUM_W-1:0]  occ_sum,
    output logic                             out_valid,
    output occ_stats_pkg::stats_t            out_stats
);
    import occ_stats_pkg::*;

    logic    s1_valid;
    logic    req_single;
    stats_t  s2_next;

    // set while min_occ is no larger than any port
    logic    min_ok;

    // stage 1 valid
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // stage 1 payload held while idle
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_sample <= in_sample;
        end
    end

    // zero or one requester
    assign req_single = (req_count <= CNT_W'(1));

    always_comb begin
        s2_next.min_port = min_port;
        s2_next.min_occ = min_occ;
        s2_next.req_count = req_count;
        s2_next.req_single = req_single;
        s2_next.occ_sum = occ_sum;
    end

    // stage 2 result held when stage 1 is empty
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_stats <= '0;
        end else begin
            out_valid <= s1_valid;
            if (s1_valid) begin
                out_stats <= s2_next;
            end
        end
    end

    always_comb begin
        min_ok = 1'b1;
        for (int k = 0; k < NUM_PORTS; k++) begin
            if (min_occ > s1_sample.occ[k*OCC_W +: OCC_W]) begin
                min_ok = 1'b0;
            end
        end
    end

    // counter result bounded by port count
    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        s1_valid |-> (req_count <= CNT_W'(NUM_PORTS)));

    // min finder really returns the minimum of the staged sample
    a_min_le_all: assert property (@(posedge clk) disable iff (rst)
        s1_valid |-> min_ok);

    // reset flushes both stages so no pulse for two cycles
    a_rst_flush: assert property (@(posedge clk) (rst || $past(rst)) |=> !out_valid);

endmodule

// ==== verilog/sat_accumulator.sv ====
module sat_accumulator (
    input  occ_stats_pkg::occ_vec_t         occ,
    output logic [occ_stats_pkg::SUM_W-1:0] sum
);
    import occ_stats_pkg::*;

    // full-width sum, never overflows
    logic [SUM_FULL_W-1:0] full_sum;

    // overflow past the reported width
    logic                  sat;

    // plain adder chain over all ports
    always_comb begin
        full_sum = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            full_sum = full_sum + SUM_FULL_W'(occ[k*OCC_W +: OCC_W]);
        end
    end

    // any bit above SUM_W set means clip
    assign sat = |full_sum[SUM_FULL_W-1:SUM_W];

    // clip to all ones
    assign sum = sat ? {SUM_W{1'b1}} : full_sum[SUM_W-1:0];

endmodule

// ==== verilog/pop_counter.sv ====
module pop_counter #(
    parameter int IN_WIDTH = 15
) (
    input  logic [IN_WIDTH-1:0]             in,
    output logic [occ_stats_pkg::CNT_W-1:0] count
);

    // input padded to the full 15-bit counter
    logic [14:0] pc_in;

    // carry bits and parities of the two first-level blocks
    logic [2:0] abc0;
    logic [2:0] abc1;
    logic       s0;
    logic       s1;

    // carry from the parity adder
    logic       b2;

    // final seven-input stage
    logic [2:0] abc2;
    logic       s2;

    // unused upper inputs read as zero
    assign pc_in = 15'(in);

    cs_gen cs0 (
        .in  (pc_in[6:0]),
        .abc (abc0),
        .s   (s0)
    );

    cs_gen cs1 (
        .in  (pc_in[13:7]),
        .abc (abc1),
        .s   (s1)
    );

    // leftover bit plus both parities
    // low bit is the count lsb, high bit joins the weight-2 pool
    assign {b2, count[0]} = 2'(pc_in[14]) + 2'(s0) + 2'(s1);

    // seven weight-2 bits counted by a (7,3) stage
    cs_gen cs_fin (
        .in  ({abc0, abc1, b2}),
        .abc (abc2),
        .s   (s2)
    );

    assign count[1] = s2;

    // weight-4 carries summed
    assign count[3:2] = 2'(abc2[0]) + 2'(abc2[1]) + 2'(abc2[2]);

endmodule

// ==== verilog/min_select.sv ====
module min_select (
    input  occ_stats_pkg::occ_vec_t          occ,
    output logic [occ_stats_pkg::PORT_W-1:0] min_port,
    output occ_stats_pkg::occ_t              min_occ
);
    import occ_stats_pkg::*;

    // per-port values split out of the packed vector
    occ_t num [NUM_PORTS];

    // comp[i][j] set when port i beats its j-th opponent
    logic [NUM_PORTS-2:0] comp [NUM_PORTS];

    // exactly one bit set, the winner
    port_mask_t min_onehot;

    genvar i, j;
    generate
        for (i = 0; i < NUM_PORTS; i = i + 1) begin : g_port
            assign num[i] = occ[i*OCC_W +: OCC_W];
            for (j = 0; j < NUM_PORTS - 1; j = j + 1) begin : g_cmp
                if (i > j) begin : g_earlier
                    // earlier port j: mirror of its own compare, so strict less
                    assign comp[i][j] = ~comp[j][i-1];
                end else begin : g_later
                    // later port j+1: ties go to the lower index
                    assign comp[i][j] = (num[i] <= num[j+1]);
                end
            end
            // winner beats every other port
            assign min_onehot[i] = &comp[i];
        end
    endgenerate

    // one-hot to binary plus masked value mux, both as and-or trees
    always_comb begin
        min_port = '0;
        min_occ = '0;
        for (int k = 0; k < NUM_PORTS; k++) begin
            min_port = min_port | ({PORT_W{min_onehot[k]}} & PORT_W'(k));
            min_occ = min_occ | ({OCC_W{min_onehot[k]}} & num[k]);
        end
    end

endmodule

// ==== verilog/cs_gen.sv ====
module cs_gen (
    input  logic [6:0] in,
    output logic [2:0] abc,
    output logic       s
);

    // group of four and group of three
    logic [3:0] grp_lo;
    logic [2:0] grp_hi;

    // ones in each group
    logic [2:0] cnt_lo;
    logic [1:0] cnt_hi;

    assign {grp_hi, grp_lo} = in;

    assign cnt_lo = 3'(grp_lo[0]) + 3'(grp_lo[1]) + 3'(grp_lo[2]) + 3'(grp_lo[3]);
    assign cnt_hi = 2'(grp_hi[0]) + 2'(grp_hi[1]) + 2'(grp_hi[2]);

    // parity of the whole word
    assign s = cnt_lo[0] ^ cnt_hi[0];

    // a: low group holds a pair
    assign abc[2] = (cnt_lo > 3'd1);

    // b: high group holds a pair
    assign abc[1] = (cnt_hi > 2'd1);

    // c: second pair in low group, or two odd leftovers pairing up
    assign abc[0] = (cnt_lo == 3'd4) | (cnt_lo[0] & cnt_hi[0]);

endmodule

// ==== verilog/occ_stats_pkg.sv ====
package occ_stats_pkg;

    // router geometry
    localparam int NUM_PORTS = 8;
    localparam int OCC_W = 5;
    localparam int PORT_W = 3;

    // count of requesters, holds 0..NUM_PORTS
    localparam int CNT_W = 4;

    // reported sum width, clips at 127
    localparam int SUM_W = 7;

    // full sum width before saturation
    localparam int SUM_FULL_W = OCC_W + $clog2(NUM_PORTS);

    // one port occupancy
    typedef logic [OCC_W-1:0] occ_t;

    // all occupancies, port 0 in low bits
    typedef logic [NUM_PORTS*OCC_W-1:0] occ_vec_t;

    // one bit per port
    typedef logic [NUM_PORTS-1:0] port_mask_t;

    // stage 1 contents
    typedef struct packed {
        occ_vec_t   occ;
        port_mask_t req;
    } sample_t;

    // reported result
    typedef struct packed {
        logic [PORT_W-1:0] min_port;
        occ_t              min_occ;
        logic [CNT_W-1:0]  req_count;
        logic              req_single;
        logic [SUM_W-1:0]  occ_sum;
    } stats_t;

endpackage
